//--- hdl/fetch_arbiter.sv
`timescale 1ns/1ps

`include "pc_config.svh"

module fetch_arbiter (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic [`NUM_HARTS-1:0]                 ready,
   input  pc_pkg::xlen_t [`NUM_HARTS-1:0]        pc_all,
   input  logic                                  fetch_ready,
   output logic [`NUM_HARTS-1:0]                 grant,
   output logic                                  fetch_valid,
   output pc_pkg::hart_id_t                      fetch_hart,
   output pc_pkg::xlen_t                         fetch_pc
);

   import pc_pkg::*;

   hart_id_t rr_ptr;       // first hart to look at next time
   hart_id_t pick;
   logic     pick_valid;
   logic     load_en;

   // first ready hart at or after the pointer
   always_comb begin
      hart_id_t idx;
      pick       = rr_ptr;
      pick_valid = 1'b0;
      for (int i = 0; i < `NUM_HARTS; i++) begin
         idx = rr_ptr + hart_id_t'(i);   // wraps with the index width
         if (!pick_valid && ready[idx]) begin
            pick       = idx;
            pick_valid = 1'b1;
         end
      end
   end

   // register is empty or being taken only while the consumer accepts
   assign load_en = fetch_ready;
   assign grant   = (load_en && pick_valid) ? (`NUM_HARTS'(1) << pick) : '0;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_valid <= 1'b0;
         rr_ptr      <= '0;
      end else if (load_en) begin
         fetch_valid <= pick_valid;
         if (pick_valid) begin
            rr_ptr <= pick + hart_id_t'(1);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load_en && pick_valid) begin
         fetch_hart <= pick;
         fetch_pc   <= pc_all[pick];
      end
   end

endmodule

//--- hdl/hart_pc.sv
`timescale 1ns/1ps

`include "pc_config.svh"

module hart_pc #(
   parameter pc_pkg::hart_id_t hart_index = '0
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              op_strobe,
   input  pc_pkg::br_op_t    op,
   input  pc_pkg::xlen_t     op_imm,
   input  pc_pkg::xlen_t     op_rs1,
   input  pc_pkg::xlen_t     op_rs2,
   input  logic              op_hazard,
   input  logic              wb_valid,
   input  pc_pkg::hart_id_t  wb_hart,
   input  pc_pkg::xlen_t     wb_data,
   input  logic              grant,
   output logic              ready,
   output logic              busy,
   output pc_pkg::xlen_t     pc
);

   import pc_pkg::*;

   hart_state_t state;
   xlen_t       pc_q;
   xlen_t       saved_imm;   // jalr offset held across the hazard
   logic        taken;
   xlen_t       pc_plus4;
   xlen_t       pc_plus_imm;
   xlen_t       jalr_sum;
   xlen_t       wb_sum;
   xlen_t       next_pc;
   logic        wb_match;
   logic        jalr_stall;

   assign wb_match   = wb_valid && (wb_hart == hart_index);
   assign jalr_stall = (op == BR_JALR) && op_hazard;

   // branch condition
   always_comb begin
      case (op)
         BR_BEQ:  taken = (op_rs1 == op_rs2);
         BR_BNE:  taken = (op_rs1 != op_rs2);
         BR_BLT:  taken = ($signed(op_rs1) < $signed(op_rs2));
         BR_BGE:  taken = ($signed(op_rs1) >= $signed(op_rs2));
         BR_BLTU: taken = (op_rs1 < op_rs2);
         BR_BGEU: taken = (op_rs1 >= op_rs2);
         default: taken = 1'b0;
      endcase
   end

   assign pc_plus4    = pc_q + xlen_t'(4);
   assign pc_plus_imm = pc_q + op_imm;
   assign jalr_sum    = op_rs1 + op_imm;
   assign wb_sum      = wb_data + saved_imm;

   always_comb begin
      case (op)
         BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU: begin
            next_pc = taken ? pc_plus_imm : pc_plus4;
         end
         BR_JAL:    next_pc = pc_plus_imm;
         BR_JALR:   next_pc = {jalr_sum[`XLEN-1:1], 1'b0};   // bit 0 cleared
         BR_EBREAK: next_pc = `TRAP_PC;
         default:   next_pc = pc_plus4;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= HS_READY;
         pc_q  <= `RESET_PC;
      end else begin
         case (state)
            HS_READY: begin
               if (grant) begin
                  state <= HS_BUSY;
               end
            end
            HS_BUSY: begin
               if (op_strobe) begin
                  if (jalr_stall) begin
                     state <= HS_WAIT_REG;
                  end else begin
                     state <= HS_READY;
                     pc_q  <= next_pc;
                  end
               end
            end
            HS_WAIT_REG: begin
               if (wb_match) begin
                  state <= HS_READY;
                  pc_q  <= {wb_sum[`XLEN-1:1], 1'b0};
               end
            end
            default: state <= HS_READY;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == HS_BUSY && op_strobe && jalr_stall) begin
         saved_imm <= op_imm;
      end
   end

   assign ready = (state == HS_READY);
   assign busy  = (state != HS_READY);
   assign pc    = pc_q;

endmodule

//--- hdl/pc_config.svh
`ifndef PC_CONFIG_SVH
`define PC_CONFIG_SVH

// data and address width
`define XLEN 64

// hardware threads in the barrel
`define NUM_HARTS 4
`define HART_ID_W 2

// pc of every hart coming out of reset
`define RESET_PC 64'h0000_0000_8000_0000

// ebreak target
`define TRAP_PC 64'h0000_0000_8000_0100

`endif

//--- hdl/pc_pkg.sv
`include "pc_config.svh"

package pc_pkg;

   typedef logic [`XLEN-1:0]      xlen_t;     // pcs, immediates, register data
   typedef logic [31:0]           instr_t;
   typedef logic [`HART_ID_W-1:0] hart_id_t;

   // next-pc operation carried from decode to the hart
   typedef enum logic [3:0] {
      BR_NONE   = 4'd0,
      BR_BEQ    = 4'd1,
      BR_BNE    = 4'd2,
      BR_BLT    = 4'd3,
      BR_BGE    = 4'd4,
      BR_BLTU   = 4'd5,
      BR_BGEU   = 4'd6,
      BR_JAL    = 4'd7,
      BR_JALR   = 4'd8,
      BR_EBREAK = 4'd9
   } br_op_t;

   typedef enum logic [1:0] {
      HS_READY    = 2'd0,   // pc valid, not fetched yet
      HS_BUSY     = 2'd1,   // in flight, waiting for retire
      HS_WAIT_REG = 2'd2    // jalr waiting on rs1 from write-back
   } hart_state_t;

endpackage

//--- hdl/pc_unit_top.sv
`timescale 1ns/1ps

`include "pc_config.svh"

module pc_unit_top (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   retire_valid,
   input  pc_pkg::hart_id_t       retire_hart,
   input  pc_pkg::instr_t         retire_instr,
   input  pc_pkg::xlen_t          rs1_data,
   input  pc_pkg::xlen_t          rs2_data,
   input  logic                   rs1_hazard,
   input  logic                   wb_valid,
   input  pc_pkg::hart_id_t       wb_hart,
   input  pc_pkg::xlen_t          wb_data,
   input  logic                   fetch_ready,
   output logic                   fetch_valid,
   output pc_pkg::hart_id_t       fetch_hart,
   output pc_pkg::xlen_t          fetch_pc,
   output logic [`NUM_HARTS-1:0]  hart_busy
);

   import pc_pkg::*;

   logic [`NUM_HARTS-1:0]  op_strobe;
   br_op_t                 op;
   xlen_t                  op_imm;
   xlen_t                  op_rs1;
   xlen_t                  op_rs2;
   logic                   op_hazard;
   logic [`NUM_HARTS-1:0]  hart_ready;
   logic [`NUM_HARTS-1:0]  grant;
   xlen_t [`NUM_HARTS-1:0] pc_all;

   retire_decode i_decode (
      .clk          (clk),
      .rst_n        (rst_n),
      .retire_valid (retire_valid),
      .retire_hart  (retire_hart),
      .retire_instr (retire_instr),
      .rs1_data     (rs1_data),
      .rs2_data     (rs2_data),
      .rs1_hazard   (rs1_hazard),
      .op_strobe    (op_strobe),
      .op           (op),
      .op_imm       (op_imm),
      .op_rs1       (op_rs1),
      .op_rs2       (op_rs2),
      .op_hazard    (op_hazard)
   );

   for (genvar g = 0; g < `NUM_HARTS; g++) begin : g_hart
      hart_pc #(
         .hart_index (hart_id_t'(g))
      ) i_hart (
         .clk       (clk),
         .rst_n     (rst_n),
         .op_strobe (op_strobe[g]),
         .op        (op),
         .op_imm    (op_imm),
         .op_rs1    (op_rs1),
         .op_rs2    (op_rs2),
         .op_hazard (op_hazard),
         .wb_valid  (wb_valid),
         .wb_hart   (wb_hart),
         .wb_data   (wb_data),
         .grant     (grant[g]),
         .ready     (hart_ready[g]),
         .busy      (hart_busy[g]),
         .pc        (pc_all[g])
      );
   end

   fetch_arbiter i_arbiter (
      .clk         (clk),
      .rst_n       (rst_n),
      .ready       (hart_ready),
      .pc_all      (pc_all),
      .fetch_ready (fetch_ready),
      .grant       (grant),
      .fetch_valid (fetch_valid),
      .fetch_hart  (fetch_hart),
      .fetch_pc    (fetch_pc)
   );

endmodule

//--- hdl/retire_decode.sv
`timescale 1ns/1ps

`include "pc_config.svh"

module retire_decode (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   retire_valid,
   input  pc_pkg::hart_id_t       retire_hart,
   input  pc_pkg::instr_t         retire_instr,
   input  pc_pkg::xlen_t          rs1_data,
   input  pc_pkg::xlen_t          rs2_data,
   input  logic                   rs1_hazard,
   output logic [`NUM_HARTS-1:0]  op_strobe,
   output pc_pkg::br_op_t         op,
   output pc_pkg::xlen_t          op_imm,
   output pc_pkg::xlen_t          op_rs1,
   output pc_pkg::xlen_t          op_rs2,
   output logic                   op_hazard
);

   import pc_pkg::*;

   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;
   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
   localparam instr_t     EBREAK_WORD = 32'h0010_0073;

   logic [6:0] opcode;
   logic [2:0] funct3;
   xlen_t      imm_b;
   xlen_t      imm_j;
   xlen_t      imm_i;
   br_op_t     dec_op;
   xlen_t      dec_imm;

   assign opcode = retire_instr[6:0];
   assign funct3 = retire_instr[14:12];

   // sign-extended immediates
   assign imm_b = {{(`XLEN-13){retire_instr[31]}}, retire_instr[31], retire_instr[7],
                   retire_instr[30:25], retire_instr[11:8], 1'b0};
   assign imm_j = {{(`XLEN-21){retire_instr[31]}}, retire_instr[31], retire_instr[19:12],
                   retire_instr[20], retire_instr[30:21], 1'b0};
   assign imm_i = {{(`XLEN-12){retire_instr[31]}}, retire_instr[31:20]};

   always_comb begin
      dec_op  = BR_NONE;
      dec_imm = '0;
      case (opcode)
         OPC_BRANCH: begin
            dec_imm = imm_b;
            case (funct3)
               3'b000:  dec_op = BR_BEQ;
               3'b001:  dec_op = BR_BNE;
               3'b100:  dec_op = BR_BLT;
               3'b101:  dec_op = BR_BGE;
               3'b110:  dec_op = BR_BLTU;
               3'b111:  dec_op = BR_BGEU;
               default: dec_op = BR_NONE;   // 010/011 are reserved
            endcase
         end
         OPC_JAL: begin
            dec_op  = BR_JAL;
            dec_imm = imm_j;
         end
         OPC_JALR: begin
            if (funct3 == 3'b000) begin
               dec_op  = BR_JALR;
               dec_imm = imm_i;
            end
         end
         OPC_SYSTEM: begin
            if (retire_instr == EBREAK_WORD) begin
               dec_op = BR_EBREAK;
            end
         end
         default: begin
            dec_op  = BR_NONE;   // plain step to pc+4
            dec_imm = '0;
         end
      endcase
   end

   // strobe is the only control here
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         op_strobe <= '0;
      end else if (retire_valid) begin
         op_strobe <= `NUM_HARTS'(1) << retire_hart;
      end else begin
         op_strobe <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if (retire_valid) begin
         op        <= dec_op;
         op_imm    <= dec_imm;
         op_rs1    <= rs1_data;
         op_rs2    <= rs2_data;
         op_hazard <= rs1_hazard;   // only looked at for jalr
      end
   end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the pc unit testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -j 0 -f vlog.f --top-module tb_pc_unit -o tb_pc_unit \
   && ./obj_dir/tb_pc_unit > sim.log 2>&1

[ -f sim.log ] && cat sim.log
grep -q "^=== PASS ===$" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- testbench/tb_pc_unit.sv
`timescale 1ns/1ps

`include "pc_config.svh"

module tb_pc_unit;

   import pc_pkg::*;

   localparam int     CYCLE_LIMIT = 3000;   // all tests together take about 300 cycles
   localparam int     OP_STEP     = 0;
   localparam int     OP_JAL      = 1;
   localparam int     OP_JALR     = 2;
   localparam int     OP_EBREAK   = 3;
   localparam int     OP_BRANCH   = 4;
   localparam instr_t ADDI_WORD   = 32'h00a0_0093;   // addi x1, x0, 10
   localparam instr_t EBREAK_WORD = 32'h0010_0073;

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  retire_valid;
   hart_id_t              retire_hart;
   instr_t                retire_instr;
   xlen_t                 rs1_data;
   xlen_t                 rs2_data;
   logic                  rs1_hazard;
   logic                  wb_valid;
   hart_id_t              wb_hart;
   xlen_t                 wb_data;
   logic                  fetch_ready;
   logic                  fetch_valid;
   hart_id_t              fetch_hart;
   xlen_t                 fetch_pc;
   logic [`NUM_HARTS-1:0] hart_busy;

   xlen_t  model_pc [`NUM_HARTS];   // expected pc of each hart
   integer seed;
   int     cycle_count = 0;

   pc_unit_top i_dut (.*);

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, the DUT stopped handing out fetches", cycle_count);
         $display("=== FAIL ===");
         $fatal(1, "simulation timed out");
      end
   end

   task automatic check_value(input string name, input xlen_t expected, input xlen_t actual);
      if (expected !== actual) begin
         $display("mismatch %s: expected %h actual %h", name, expected, actual);
         $display("=== FAIL ===");
         $fatal(1, "check failed in %s", name);
      end
   endtask

   function automatic instr_t branch_word(input logic [2:0] funct3, input logic [12:0] imm);
      return {imm[12], imm[10:5], 5'd2, 5'd1, funct3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic instr_t jal_word(input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
   endfunction

   function automatic instr_t jalr_word(input logic [11:0] imm);
      return {imm, 5'd5, 3'b000, 5'd1, 7'b1100111};
   endfunction

   function automatic logic [2:0] branch_funct3(input int k);
      case (k)
         0:       return 3'b000;   // beq
         1:       return 3'b001;   // bne
         2:       return 3'b100;   // blt
         3:       return 3'b101;   // bge
         4:       return 3'b110;   // bltu
         default: return 3'b111;   // bgeu
      endcase
   endfunction

   function automatic logic branch_taken(input logic [2:0] funct3, input xlen_t a, input xlen_t b);
      case (funct3)
         3'b000:  return a == b;
         3'b001:  return a != b;
         3'b100:  return $signed(a) < $signed(b);
         3'b101:  return $signed(a) >= $signed(b);
         3'b110:  return a < b;
         default: return a >= b;
      endcase
   endfunction

   task automatic drive_retire(input int hart, input instr_t instr, input xlen_t a,
                               input xlen_t b, input logic hazard);
      retire_valid = 1'b1;
      retire_hart  = hart_id_t'(hart);
      retire_instr = instr;
      rs1_data     = a;
      rs2_data     = b;
      rs1_hazard   = hazard;
   endtask

   // one-cycle retire strobe, returns on the falling edge after it was sampled
   task automatic send_retire(input int hart, input instr_t instr, input xlen_t a,
                              input xlen_t b, input logic hazard);
      drive_retire(hart, instr, a, b, hazard);
      @(negedge clk);
      retire_valid = 1'b0;
      rs1_hazard   = 1'b0;
   endtask

   task automatic take_fetch(output int hart, output xlen_t pc);
      while (!fetch_valid) @(negedge clk);
      hart = int'(fetch_hart);
      pc   = fetch_pc;
      @(negedge clk);   // taken at the rising edge in between
   endtask

   task automatic expect_fetch(input string name, input int hart, input xlen_t pc);
      int    got_hart;
      xlen_t got_pc;
      take_fetch(got_hart, got_pc);
      check_value(name, xlen_t'(hart), xlen_t'(got_hart));
      check_value(name, pc, got_pc);
   endtask

   task automatic idle_cycles(input string name, input int cycles);
      repeat (cycles) begin
         check_value(name, '0, xlen_t'(fetch_valid));
         @(negedge clk);
      end
   endtask

   // random operation of one kind and the pc it leads to
   task automatic random_op(input int kind, input xlen_t pc, output instr_t instr,
                            output xlen_t a, output xlen_t b, output xlen_t target);
      logic [31:0] rnd;
      logic [2:0]  f3;
      logic [12:0] imm13;
      logic [20:0] imm21;
      rnd   = $random(seed);
      a     = {$random(seed), $random(seed)};
      b     = {$random(seed), $random(seed)};
      imm13 = {rnd[12:1], 1'b0};
      imm21 = {rnd[20:1], 1'b0};
      case (kind)
         OP_JAL: begin
            instr  = jal_word(imm21);
            target = pc + {{(`XLEN-21){imm21[20]}}, imm21};
         end
         OP_JALR: begin
            instr  = jalr_word(rnd[11:0]);
            target = (a + {{(`XLEN-12){rnd[11]}}, rnd[11:0]}) & ~xlen_t'(1);
         end
         OP_EBREAK: begin
            instr  = EBREAK_WORD;
            target = `TRAP_PC;
         end
         OP_BRANCH: begin
            f3     = branch_funct3(int'(rnd[31:29]) % 6);
            instr  = branch_word(f3, imm13);
            target = branch_taken(f3, a, b) ? pc + {{(`XLEN-13){imm13[12]}}, imm13}
                                            : pc + xlen_t'(4);
         end
         default: begin
            instr  = ADDI_WORD;
            target = pc + xlen_t'(4);
         end
      endcase
   endtask

   task automatic run_op(input string name, input int hart, input int kind);
      instr_t instr;
      xlen_t  a;
      xlen_t  b;
      xlen_t  target;
      random_op(kind, model_pc[hart], instr, a, b, target);
      send_retire(hart, instr, a, b, 1'b0);
      expect_fetch(name, hart, target);
      model_pc[hart] = target;
   endtask

   task automatic reset_round_robin();
      int    hart;
      xlen_t pc;
      for (int i = 0; i < `NUM_HARTS; i++) begin
         take_fetch(hart, pc);
         check_value("reset order hart", xlen_t'(i), xlen_t'(hart));
         check_value("reset order pc", `RESET_PC, pc);
      end
      check_value("reset order busy", xlen_t'({`NUM_HARTS{1'b1}}), xlen_t'(hart_busy));
   endtask

   task automatic cond_branches();
      int          hart;
      logic [2:0]  f3;
      logic [12:0] imm;
      xlen_t       a;
      xlen_t       b;
      xlen_t       expected;
      string       name;
      for (int k = 0; k < 6; k++) begin
         for (int t = 0; t < 3; t++) begin
            hart = (k * 3 + t) % `NUM_HARTS;
            f3   = branch_funct3(k);
            imm  = 13'($random(seed)) & 13'h1ffe;
            a    = {$random(seed), $random(seed)};
            case (t)
               0:       b = {$random(seed), $random(seed)};
               1:       b = a;
               default: b = {~a[`XLEN-1], a[`XLEN-2:0]};   // sign flipped
            endcase
            expected = branch_taken(f3, a, b) ? model_pc[hart] + {{(`XLEN-13){imm[12]}}, imm}
                                              : model_pc[hart] + xlen_t'(4);
            name = $sformatf("branch funct3 %0d case %0d", f3, t);
            send_retire(hart, branch_word(f3, imm), a, b, 1'b0);
            idle_cycles(name, 2);
            check_value(name, xlen_t'(1), xlen_t'(fetch_valid));
            check_value(name, xlen_t'(hart), xlen_t'(fetch_hart));
            check_value(name, expected, fetch_pc);
            model_pc[hart] = expected;
            @(negedge clk);
         end
      end
   endtask

   task automatic jumps_and_traps();
      for (int r = 0; r < 2; r++) begin
         run_op("jal", r, OP_JAL);
         run_op("jalr", (r + 1) % `NUM_HARTS, OP_JALR);
         run_op("ebreak", (r + 2) % `NUM_HARTS, OP_EBREAK);
         run_op("plain step", (r + 3) % `NUM_HARTS, OP_STEP);
      end
   endtask

   task automatic jalr_hazard();
      logic [11:0] imm;
      xlen_t       data;
      xlen_t       target;
      imm    = 12'($random(seed));
      data   = {$random(seed), $random(seed)};
      target = (data + {{(`XLEN-12){imm[11]}}, imm}) & ~xlen_t'(1);
      send_retire(2, jalr_word(imm), {$random(seed), $random(seed)}, '0, 1'b1);   // stale rs1
      idle_cycles("jalr hazard wait", 2);
      send_retire(2, jalr_word(~imm), '0, '0, 1'b0);   // ignored while waiting on rs1
      idle_cycles("jalr hazard retire ignored", 3);
      check_value("jalr hazard busy", xlen_t'(1), xlen_t'(hart_busy[2]));
      wb_valid = 1'b1;
      wb_hart  = hart_id_t'(1);
      wb_data  = ~data;
      idle_cycles("jalr hazard other write-back", 1);
      wb_valid = 1'b0;
      idle_cycles("jalr hazard other write-back", 4);
      wb_valid = 1'b1;
      wb_hart  = hart_id_t'(2);
      wb_data  = data;
      idle_cycles("jalr hazard write-back", 1);
      wb_valid = 1'b0;
      idle_cycles("jalr hazard write-back", 1);
      check_value("jalr hazard fetch timing", xlen_t'(1), xlen_t'(fetch_valid));
      expect_fetch("jalr hazard target", 2, target);
      model_pc[2] = target;
   endtask

   task automatic fetch_backpressure();
      instr_t instr;
      xlen_t  a;
      xlen_t  b;
      xlen_t  first_pc;
      xlen_t  second_pc;
      random_op(OP_BRANCH, model_pc[1], instr, a, b, first_pc);
      send_retire(1, instr, a, b, 1'b0);
      while (!fetch_valid) @(negedge clk);
      fetch_ready = 1'b0;
      random_op(OP_JAL, model_pc[3], instr, a, b, second_pc);
      send_retire(3, instr, a, b, 1'b0);
      for (int i = 0; i < 8; i++) begin
         check_value("backpressure hold valid", xlen_t'(1), xlen_t'(fetch_valid));
         check_value("backpressure hold hart", xlen_t'(1), xlen_t'(fetch_hart));
         check_value("backpressure hold pc", first_pc, fetch_pc);
         if (i == 3) begin
            check_value("backpressure hart 3 ready", '0, xlen_t'(hart_busy[3]));
            drive_retire(3, EBREAK_WORD, '0, '0, 1'b0);   // hart 3 is not busy
         end else begin
            retire_valid = 1'b0;
         end
         @(negedge clk);
      end
      check_value("backpressure hart 3 ready", '0, xlen_t'(hart_busy[3]));
      fetch_ready = 1'b1;
      expect_fetch("backpressure release first", 1, first_pc);
      expect_fetch("backpressure release second", 3, second_pc);
      model_pc[1] = first_pc;
      model_pc[3] = second_pc;
   endtask

   task automatic back_to_back_retires();
      instr_t instr [`NUM_HARTS];
      xlen_t  a [`NUM_HARTS];
      xlen_t  b [`NUM_HARTS];
      xlen_t  target [`NUM_HARTS];
      xlen_t  seen_pc [`NUM_HARTS];
      int     seen [`NUM_HARTS];
      int     hart;
      int     sent;
      int     got;
      for (int r = 0; r < 3; r++) begin
         for (int h = 0; h < `NUM_HARTS; h++) begin
            random_op((h + r) % 5, model_pc[h], instr[h], a[h], b[h], target[h]);
            seen[h] = 0;
         end
         sent = 0;
         got  = 0;
         while (got < `NUM_HARTS) begin
            if (fetch_valid) begin
               seen[fetch_hart]++;
               seen_pc[fetch_hart] = fetch_pc;
               got++;
            end
            if (sent < `NUM_HARTS) begin
               hart = (r % 2 == 1) ? `NUM_HARTS - 1 - sent : sent;   // odd rounds descend
               drive_retire(hart, instr[hart], a[hart], b[hart], 1'b0);
               sent++;
            end else begin
               retire_valid = 1'b0;
            end
            @(negedge clk);
         end
         for (int h = 0; h < `NUM_HARTS; h++) begin
            check_value("back to back fetch count", xlen_t'(1), xlen_t'(seen[h]));
            check_value("back to back pc", target[h], seen_pc[h]);
            model_pc[h] = target[h];
         end
      end
   endtask

   initial begin
      seed         = 23;
      rst_n        = 1'b0;
      retire_valid = 1'b0;
      retire_hart  = '0;
      retire_instr = '0;
      rs1_data     = '0;
      rs2_data     = '0;
      rs1_hazard   = 1'b0;
      wb_valid     = 1'b0;
      wb_hart      = '0;
      wb_data      = '0;
      fetch_ready  = 1'b1;
      for (int h = 0; h < `NUM_HARTS; h++) begin
         model_pc[h] = `RESET_PC;
      end
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      reset_round_robin();
      cond_branches();
      jumps_and_traps();
      jalr_hazard();
      fetch_backpressure();
      back_to_back_retires();
      $display("=== PASS ===");
      $finish;
   end

endmodule

//--- vlog.f
+incdir+hdl
hdl/pc_pkg.sv
hdl/retire_decode.sv
hdl/hart_pc.sv
hdl/fetch_arbiter.sv
hdl/pc_unit_top.sv
testbench/tb_pc_unit.sv
